//--- common/exu_pkg.sv
// exu_pkg: widths, instruction encodings and operation codes of the execute unit
`default_nettype none

package exu_pkg;

	localparam int XLEN      = 32;
	localparam int ACC_W     = 64;
	localparam int REG_IDX_W = 5;

	typedef logic [XLEN-1:0]             xlen_t;
	typedef logic signed [ACC_W-1:0]     acc_t;
	typedef logic [REG_IDX_W-1:0]        reg_idx_t;
	typedef logic [31:0]                 inst_t;

	// major opcodes
	localparam logic [6:0] OPC_R    = 7'b0110011;
	localparam logic [6:0] OPC_I    = 7'b0010011;
	localparam logic [6:0] OPC_LI   = 7'b0000111;
	localparam logic [6:0] OPC_ACC  = 7'b1111111;
	localparam logic [6:0] OPC_ACCI = 7'b0011111;
	localparam logic [6:0] OPC_ACCX = 7'b0111111; // funct3 000 trans, 111 set
	localparam logic [6:0] OPC_DIV  = 7'b1011111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;
	localparam logic [6:0] F7_ROT  = 7'b0001111;
	localparam logic [6:0] F7_DOTP = 7'b1111111;

	// codes follow the original alucontrol table, 1010 and 1111 unused
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SUB    = 4'b0001,
		ALU_SLL    = 4'b0010,
		ALU_SLT    = 4'b0011,
		ALU_SLE    = 4'b0100,
		ALU_XOR    = 4'b0101,
		ALU_SRA    = 4'b0110,
		ALU_SRL    = 4'b0111,
		ALU_OR     = 4'b1000,
		ALU_AND    = 4'b1001,
		ALU_ROTCW  = 4'b1011,
		ALU_ROTACW = 4'b1100,
		ALU_PASS_B = 4'b1101,
		ALU_DOTP   = 4'b1110
	} alu_op_t;

	typedef enum logic [2:0] {
		MAC_NONE  = 3'd0,
		MAC_MAC   = 3'd1,
		MAC_CLEAR = 3'd2,
		MAC_TRANS = 3'd3,
		MAC_DIV   = 3'd4
	} mac_op_t;

	function automatic logic [6:0] get_opcode(inst_t inst);
		return inst[6:0];
	endfunction

	function automatic logic [2:0] get_funct3(inst_t inst);
		return inst[14:12];
	endfunction

	function automatic logic [6:0] get_funct7(inst_t inst);
		return inst[31:25];
	endfunction

	function automatic reg_idx_t get_rd(inst_t inst);
		return inst[11:7];
	endfunction

	// sign extended I immediate
	function automatic xlen_t imm_i(inst_t inst);
		return {{(XLEN-12){inst[31]}}, inst[31:20]};
	endfunction

endpackage

`default_nettype wire

//--- design/exu_decode.sv
// exu_decode: maps the instruction to ALU or MAC operation and registers the execute stage
`default_nettype none

module exu_decode (
	input logic clk,
	input logic res,
	input logic in_valid,
	input exu_pkg::inst_t in_inst,
	input exu_pkg::xlen_t in_rs1,
	input exu_pkg::xlen_t in_rs2,
	output logic ex_valid,
	output logic ex_illegal,
	output exu_pkg::reg_idx_t ex_rd,
	output exu_pkg::alu_op_t ex_alu_op,
	output exu_pkg::mac_op_t ex_mac_op,
	output exu_pkg::xlen_t ex_a,
	output exu_pkg::xlen_t ex_b
);
	import exu_pkg::*;

	alu_op_t dec_alu;
	mac_op_t dec_mac;
	logic    dec_illegal;
	logic    use_imm;

	always_comb
	begin
		dec_alu = ALU_ADD;
		dec_mac = MAC_NONE;
		dec_illegal = 1'b0;
		use_imm = 1'b0;
		case (get_opcode(in_inst))
			OPC_R:
			begin
				case ({get_funct7(in_inst), get_funct3(in_inst)})
					{F7_BASE, 3'b000}: dec_alu = ALU_ADD;
					{F7_ALT, 3'b000}:  dec_alu = ALU_SUB;
					{F7_BASE, 3'b001}: dec_alu = ALU_SLL;
					{F7_ALT, 3'b010}:  dec_alu = ALU_SLT;
					{F7_BASE, 3'b011}: dec_alu = ALU_SLE;
					{F7_BASE, 3'b100}: dec_alu = ALU_XOR;
					{F7_BASE, 3'b101}: dec_alu = ALU_SRA;
					{F7_ALT, 3'b101}:  dec_alu = ALU_SRL;
					{F7_BASE, 3'b110}: dec_alu = ALU_OR;
					{F7_BASE, 3'b111}: dec_alu = ALU_AND;
					{F7_ROT, 3'b000}:  dec_alu = ALU_ROTCW;
					{F7_ROT, 3'b001}:  dec_alu = ALU_ROTACW;
					{F7_DOTP, 3'b000}: dec_alu = ALU_DOTP;
					default:           dec_illegal = 1'b1;
				endcase
			end
			OPC_I:
			begin
				use_imm = 1'b1;
				case (get_funct3(in_inst))
					3'b000:  dec_alu = ALU_ADD;
					3'b001:  dec_alu = ALU_SLL;
					3'b010:  dec_alu = ALU_SLT;
					3'b011:  dec_alu = ALU_SLE;
					3'b100:  dec_alu = ALU_XOR;
					3'b101:  dec_alu = ALU_SRA;
					3'b110:  dec_alu = ALU_OR;
					default: dec_alu = ALU_AND;
				endcase
			end
			OPC_LI:
			begin
				dec_alu = ALU_PASS_B; // li rd, imm
				use_imm = 1'b1;
			end
			OPC_ACC:  dec_mac = MAC_MAC;
			OPC_ACCI:
			begin
				dec_mac = MAC_MAC;
				use_imm = 1'b1;
			end
			OPC_ACCX:
			begin
				if (get_funct3(in_inst) == 3'b000)
					dec_mac = MAC_TRANS;
				else if (get_funct3(in_inst) == 3'b111)
					dec_mac = MAC_CLEAR;
				else
					dec_illegal = 1'b1;
			end
			OPC_DIV:  dec_mac = MAC_DIV; // ac / rs1
			default:  dec_illegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge res)
	begin
		if (!res)
		begin
			ex_valid <= 1'b0;
			ex_illegal <= 1'b0;
			ex_alu_op <= ALU_ADD;
			ex_mac_op <= MAC_NONE;
		end
		else
		begin
			ex_valid <= in_valid;
			ex_illegal <= in_valid && dec_illegal;
			ex_alu_op <= dec_alu;
			ex_mac_op <= dec_mac;
		end
	end

	always_ff @(posedge clk)
	begin
		ex_rd <= get_rd(in_inst);
		ex_a <= in_rs1;
		ex_b <= use_imm ? imm_i(in_inst) : in_rs2;
	end

	// an illegal instruction must never reach the accumulator
	illegal_no_mac: assert property (@(posedge clk) disable iff (!res)
		ex_illegal |-> ex_mac_op == MAC_NONE);

endmodule

`default_nettype wire

//--- alu/sat_alu.sv
// sat_alu: combinational ALU with saturating add/sub, rotates and bytewise dot product
`default_nettype none

module sat_alu (
	input logic clk,
	input logic res,
	input logic valid,
	input exu_pkg::alu_op_t op,
	input exu_pkg::xlen_t a,
	input exu_pkg::xlen_t b,
	output exu_pkg::xlen_t data,
	output logic sat
);
	import exu_pkg::*;

	xlen_t sum;
	xlen_t diff;
	xlen_t sat_val;
	xlen_t dot;
	logic  add_ovf;
	logic  sub_ovf;
	logic [4:0] sh;
	logic [2*XLEN-1:0] rot_r;
	logic [2*XLEN-1:0] rot_l;

	assign sh = b[4:0];
	assign sum = a + b;
	assign diff = a - b;
	assign add_ovf = (a[XLEN-1] == b[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
	assign sub_ovf = (a[XLEN-1] != b[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);
	// overflow direction follows the sign of a
	assign sat_val = a[XLEN-1] ? {1'b1, {(XLEN-1){1'b0}}} : {1'b0, {(XLEN-1){1'b1}}};

	assign rot_r = {a, a} >> sh;
	assign rot_l = {a, a} << sh;

	assign dot = a[7:0] * b[7:0] + a[15:8] * b[15:8]
		+ a[23:16] * b[23:16] + a[31:24] * b[31:24];

	always_comb
	begin
		data = '0;
		sat = 1'b0;
		case (op)
			ALU_ADD:
			begin
				data = add_ovf ? sat_val : sum;
				sat = add_ovf;
			end
			ALU_SUB:
			begin
				data = sub_ovf ? sat_val : diff;
				sat = sub_ovf;
			end
			ALU_SLL:    data = a << sh;
			ALU_SLT:    data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLE:    data = ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
			ALU_XOR:    data = a ^ b;
			ALU_SRA:    data = $signed(a) >>> sh;
			ALU_SRL:    data = a >> sh;
			ALU_OR:     data = a | b;
			ALU_AND:    data = a & b;
			ALU_ROTCW:  data = rot_r[XLEN-1:0]; // bit i takes a[(i+sh)%32]
			ALU_ROTACW: data = rot_l[2*XLEN-1:XLEN];
			ALU_PASS_B: data = b;
			ALU_DOTP:   data = dot;
			default:    data = '0;
		endcase
	end

	op_known: assert property (@(posedge clk) disable iff (!res)
		valid |-> op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLE, ALU_XOR,
			ALU_SRA, ALU_SRL, ALU_OR, ALU_AND, ALU_ROTCW, ALU_ROTACW,
			ALU_PASS_B, ALU_DOTP});

endmodule

`default_nettype wire

//--- mac/mac_unit.sv
// mac_unit: 64-bit accumulator with saturating multiply-accumulate, transfer, clear and divide
`default_nettype none

module mac_unit (
	input logic clk,
	input logic res,
	input logic valid,
	input logic illegal,
	input exu_pkg::mac_op_t op,
	input exu_pkg::xlen_t a,
	input exu_pkg::xlen_t b,
	output exu_pkg::xlen_t data,
	output logic sat
);
	import exu_pkg::*;

	acc_t acc_q;
	acc_t acc_d;
	acc_t prod;
	acc_t sum;
	acc_t divisor;
	acc_t quot;
	acc_t rem;
	acc_t half;
	acc_t quot_rnd;
	logic ovf;
	logic acc_we;

	assign prod = $signed(a) * $signed(b);
	assign sum = acc_q + prod;
	assign ovf = (acc_q[ACC_W-1] == prod[ACC_W-1]) && (sum[ACC_W-1] != acc_q[ACC_W-1]);

	// divide by one when a is zero, result is masked below
	assign divisor = (a == '0) ? acc_t'(1) : acc_t'($signed(a));
	assign quot = acc_q / divisor;
	assign rem = acc_q % divisor;
	assign half = divisor >>> 1;
	assign quot_rnd = (rem > half) ? quot + acc_t'(1) : quot;

	assign acc_we = valid && !illegal; // acc_d keeps acc_q for the other ops

	always_comb
	begin
		case (op)
			MAC_MAC:
			begin
				if (!ovf)
					acc_d = sum;
				else if (acc_q[ACC_W-1])
					acc_d = {1'b1, {(ACC_W-1){1'b0}}}; // most negative
				else
					acc_d = {1'b0, {(ACC_W-1){1'b1}}};
			end
			MAC_CLEAR: acc_d = '0;
			default:   acc_d = acc_q;
		endcase
	end

	always_ff @(posedge clk or negedge res)
	begin
		if (!res)
			acc_q <= '0;
		else if (acc_we)
			acc_q <= acc_d;
	end

	always_comb
	begin
		data = '0;
		sat = 1'b0;
		case (op)
			MAC_MAC:
			begin
				data = acc_d[XLEN-1:0]; // running value, low word
				sat = ovf;
			end
			MAC_TRANS: data = acc_q[XLEN-1:0];
			MAC_DIV:
			begin
				if (a == '0)
					sat = 1'b1;
				else
					data = quot_rnd[XLEN-1:0];
			end
			default:   data = '0;
		endcase
	end

	acc_hold: assert property (@(posedge clk) disable iff (!res)
		!(valid && !illegal && (op == MAC_MAC || op == MAC_CLEAR)) |=> $stable(acc_q));

endmodule

`default_nettype wire

//--- design/exu_writeback.sv
// exu_writeback: picks the ALU or MAC result and registers the output strobe
`default_nettype none

module exu_writeback (
	input logic clk,
	input logic res,
	input logic ex_valid,
	input logic ex_illegal,
	input exu_pkg::reg_idx_t ex_rd,
	input exu_pkg::mac_op_t ex_mac_op,
	input exu_pkg::xlen_t alu_data,
	input exu_pkg::xlen_t mac_data,
	input logic alu_sat,
	input logic mac_sat,
	output logic out_valid,
	output logic out_illegal,
	output logic out_wr,
	output exu_pkg::reg_idx_t out_rd,
	output exu_pkg::xlen_t out_data,
	output logic out_sat
);
	import exu_pkg::*;

	logic  use_mac;
	logic  acc_only;
	xlen_t sel_data;
	logic  sel_sat;

	assign use_mac = (ex_mac_op != MAC_NONE);
	assign acc_only = (ex_mac_op == MAC_MAC) || (ex_mac_op == MAC_CLEAR); // no rd write
	assign sel_data = ex_illegal ? '0 : (use_mac ? mac_data : alu_data);
	assign sel_sat = !ex_illegal && (use_mac ? mac_sat : alu_sat);

	always_ff @(posedge clk or negedge res)
	begin
		if (!res)
		begin
			out_valid <= 1'b0;
			out_illegal <= 1'b0;
			out_wr <= 1'b0;
			out_sat <= 1'b0;
		end
		else
		begin
			out_valid <= ex_valid;
			out_illegal <= ex_valid && ex_illegal;
			out_wr <= ex_valid && !ex_illegal && !acc_only && (ex_rd != '0);
			out_sat <= ex_valid && sel_sat;
		end
	end

	always_ff @(posedge clk)
	begin
		out_rd <= ex_rd;
		out_data <= sel_data;
	end

endmodule

`default_nettype wire

//--- design/exu_top.sv
// exu_top: execute unit joining decode, saturating ALU, MAC and writeback
`default_nettype none

module exu_top (
	input logic clk,
	input logic res,
	input logic in_valid,
	input exu_pkg::inst_t in_inst,
	input exu_pkg::xlen_t in_rs1,
	input exu_pkg::xlen_t in_rs2,
	output logic out_valid,
	output logic out_illegal,
	output logic out_wr,
	output exu_pkg::reg_idx_t out_rd,
	output exu_pkg::xlen_t out_data,
	output logic out_sat
);
	import exu_pkg::*;

	logic     ex_valid;
	logic     ex_illegal;
	reg_idx_t ex_rd;
	alu_op_t  ex_alu_op;
	mac_op_t  ex_mac_op;
	xlen_t    ex_a;
	xlen_t    ex_b;
	xlen_t    alu_data;
	xlen_t    mac_data;
	logic     alu_sat;
	logic     mac_sat;

	exu_decode i_exu_decode (
		.clk(clk), .res(res),
		.in_valid(in_valid), .in_inst(in_inst), .in_rs1(in_rs1), .in_rs2(in_rs2),
		.ex_valid(ex_valid), .ex_illegal(ex_illegal), .ex_rd(ex_rd),
		.ex_alu_op(ex_alu_op), .ex_mac_op(ex_mac_op), .ex_a(ex_a), .ex_b(ex_b)
	);

	sat_alu i_sat_alu (
		.clk(clk), .res(res), .valid(ex_valid), .op(ex_alu_op),
		.a(ex_a), .b(ex_b), .data(alu_data), .sat(alu_sat)
	);

	mac_unit i_mac_unit (
		.clk(clk), .res(res), .valid(ex_valid), .illegal(ex_illegal), .op(ex_mac_op),
		.a(ex_a), .b(ex_b), .data(mac_data), .sat(mac_sat)
	);

	exu_writeback i_exu_writeback (
		.clk(clk), .res(res),
		.ex_valid(ex_valid), .ex_illegal(ex_illegal), .ex_rd(ex_rd), .ex_mac_op(ex_mac_op),
		.alu_data(alu_data), .mac_data(mac_data), .alu_sat(alu_sat), .mac_sat(mac_sat),
		.out_valid(out_valid), .out_illegal(out_illegal), .out_wr(out_wr),
		.out_rd(out_rd), .out_data(out_data), .out_sat(out_sat)
	);

endmodule

`default_nettype wire

//--- dv/exu_tb.sv
// exu_tb: trace driven testbench for the execute unit with an in-order scoreboard
`default_nettype none

module exu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import exu_pkg::*;

	localparam int DRAIN_LIMIT = 10;

	typedef struct packed {
		int       line;
		int       cyc;
		logic     ill;
		logic     wr;
		reg_idx_t rd;
		xlen_t    data;
		logic     sat;
	} expect_t;

	logic     clk;
	logic     res;
	logic     in_valid;
	inst_t    in_inst;
	xlen_t    in_rs1;
	xlen_t    in_rs2;
	logic     out_valid;
	logic     out_illegal;
	logic     out_wr;
	reg_idx_t out_rd;
	xlen_t    out_data;
	logic     out_sat;

	expect_t  pend_q[$]; // instructions in flight, oldest first
	int       errors;
	int       results;
	int       lines;
	int       cyc;
	int       seed;

	exu_top i_exu_top (
		.clk(clk), .res(res),
		.in_valid(in_valid), .in_inst(in_inst), .in_rs1(in_rs1), .in_rs2(in_rs2),
		.out_valid(out_valid), .out_illegal(out_illegal), .out_wr(out_wr),
		.out_rd(out_rd), .out_data(out_data), .out_sat(out_sat)
	);

	always #5 clk = ~clk;

	task automatic check_data(input xlen_t got, input xlen_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] t=%0t out_data got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_rd(input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] t=%0t out_rd got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk)
	begin
		expect_t e;
		cyc = cyc + 1;
		if (out_valid === 1'b1)
		begin
			if (pend_q.size() == 0)
			begin
				errors++;
				$display("result strobe at %0t with no instruction in flight", $time);
			end
			else
			begin
				e = pend_q.pop_front();
				results++;
				if (cyc != e.cyc)
				begin
					errors++;
					$display("line %0d arrived in cycle %0d instead of cycle %0d",
						e.line, cyc, e.cyc);
				end
				check_flag("out_illegal", out_illegal, e.ill);
				check_flag("out_wr", out_wr, e.wr);
				check_rd(out_rd, e.rd);
				check_data(out_data, e.data);
				check_flag("out_sat", out_sat, e.sat);
			end
		end
		else if (pend_q.size() != 0 && cyc >= pend_q[0].cyc)
		begin
			e = pend_q.pop_front();
			errors++;
			$display("timeout: no result for trace line %0d within 2 cycles", e.line);
		end
	end

	initial
	begin
		int       fd;
		int       n;
		int       gap;
		int       wait_cnt;
		string    text;
		inst_t    t_inst;
		xlen_t    t_rs1;
		xlen_t    t_rs2;
		logic     t_ill;
		logic     t_wr;
		reg_idx_t t_rd;
		xlen_t    t_data;
		logic     t_sat;
		expect_t  e;

		clk = 1'b0;
		res = 1'b0;
		in_valid = 1'b0;
		in_inst = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		errors = 0;
		results = 0;
		lines = 0;
		cyc = 0;
		seed = 32'hd857;
		repeat (2) @(posedge clk);
		res <= 1'b1;

		fd = $fopen("dv/exu_trace.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("cannot open the trace file dv/exu_trace.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				text = "";
				n = $fgets(text, fd);
				if (n > 1 && text.getc(0) != 8'h23) // skip comments and blank lines
				begin
					n = $sscanf(text, "%h %h %h %h %h %h %h %h", t_inst, t_rs1, t_rs2,
						t_ill, t_wr, t_rd, t_data, t_sat);
					if (n != 8)
					begin
						errors++;
						$display("trace entry after line %0d could not be parsed", lines);
					end
					else
					begin
						@(posedge clk);
						in_valid <= 1'b1;
						in_inst <= t_inst;
						in_rs1 <= t_rs1;
						in_rs2 <= t_rs2;
						lines++;
						e.line = lines;
						e.cyc = cyc + 3; // sampled next edge, result two cycles on
						e.ill = t_ill;
						e.wr = t_wr;
						e.rd = t_rd;
						e.data = t_data;
						e.sat = t_sat;
						pend_q.push_back(e);
						gap = $random(seed) & 3;
						if (t_inst[4:0] == 5'b11111)
							gap = 0; // mac opcodes go back-to-back
						repeat (gap)
						begin
							@(posedge clk);
							in_valid <= 1'b0;
						end
					end
				end
			end
			$fclose(fd);
		end
		@(posedge clk);
		in_valid <= 1'b0;

		wait_cnt = 0;
		while (pend_q.size() != 0 && wait_cnt < DRAIN_LIMIT)
		begin
			@(posedge clk);
			wait_cnt++;
		end
		if (pend_q.size() != 0)
		begin
			errors++;
			$display("timeout: %0d results never arrived", pend_q.size());
		end
		if (lines == 0 || results != lines)
		begin
			errors++;
			$display("got %0d results for %0d trace lines", results, lines);
		end

		$display("errors: %0d, results: %0d of %0d lines", errors, results, lines);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/exu_trace.txt
# columns in hex: inst rs1 rs2 illegal wr rd data sat, then an optional mnemonic
# expected values follow the execute unit rules, accumulator starts at zero
002081b3 00000005 00000007 0 1 03 0000000c 0  # add
402081b3 00000005 00000007 0 1 03 fffffffe 0  # sub
002091b3 00000003 00000024 0 1 03 00000030 0  # sll by low 5 bits
4020a1b3 fffffff0 00000005 0 1 03 00000001 0  # slt
0020b1b3 00000007 00000007 0 1 03 00000001 0  # sle equal
0020b1b3 80000000 ffffffff 0 1 03 00000001 0  # sle negative
0020c1b3 ff00ff00 0ff00ff0 0 1 03 f0f0f0f0 0  # xor
0020d1b3 80000010 00000004 0 1 03 f8000001 0  # sra
4020d1b3 80000010 00000004 0 1 03 08000001 0  # srl
0020e1b3 0000f0f0 00000f0f 0 1 03 0000ffff 0  # or
0020f1b3 12345678 0000ffff 0 1 03 00005678 0  # and
00208033 00000001 00000002 0 0 00 00000003 0  # add to x0
fff08213 00000010 deadbeef 0 1 04 0000000f 0  # addi -1
0030d213 ffffff00 00000000 0 1 04 ffffffe0 0  # srai 3
80000207 11111111 22222222 0 1 04 fffff800 0  # li -2048
002081b3 7fffffff 00000001 0 1 03 7fffffff 1  # add overflow
402081b3 80000000 00000001 0 1 03 80000000 1  # sub overflow
002081b3 80000000 ffffffff 0 1 03 80000000 1  # add negative overflow
1e2081b3 12345678 00000008 0 1 03 78123456 0  # rotcw 8
1e2091b3 78123456 00000008 0 1 03 12345678 0  # rotacw 8
1e2081b3 12345678 00000024 0 1 03 81234567 0  # rotcw 36 is 4
fe2081b3 01020304 05060708 0 1 03 00000046 0  # dotp
fe2081b3 ffffffff ffffffff 0 1 03 0003f804 0  # dotp max bytes
0020807f 00000003 00000004 0 0 00 0000000c 0  # acc
0020807f fffffffe 00000005 0 0 00 00000002 0  # acc negative product
0640801f 00000007 00000000 0 0 00 000002be 0  # acci 100
000082bf 00000000 00000000 0 1 05 000002be 0  # trans
0000835f 00000004 00000000 0 1 06 000000af 0  # div, remainder equals half
0000835f 00000008 00000000 0 1 06 00000058 0  # div rounds up
0000835f 00000000 00000000 0 1 06 00000000 1  # div by zero
0000f03f 00000000 00000000 0 0 00 00000000 0  # clear
000082bf 00000000 00000000 0 1 05 00000000 0  # trans after clear
0020807f 80000000 80000000 0 0 00 00000000 0  # acc 2^62
0020807f 80000000 80000000 0 0 00 ffffffff 1  # acc saturates
0020837b 00000003 00000004 1 0 06 00000000 0  # unknown opcode
402091b3 00000003 00000004 1 0 03 00000000 0  # unknown funct
000082bf 00000000 00000000 0 1 05 ffffffff 0  # trans, accumulator kept

//--- vlog.f
common/exu_pkg.sv
design/exu_decode.sv
alu/sat_alu.sv
mac/mac_unit.sv
design/exu_writeback.sv
design/exu_top.sv
dv/exu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module exu_tb -f vlog.f -o exu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/exu_sim)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$sim_out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1
